/* verilog.f */
+incdir+dv
verilog/controlPkg.sv
verilog/specialDecoder.sv
verilog/mulExtDecoder.sv
verilog/immDecoder.sv
verilog/controller.sv
dv/controllerTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module controllerTb -Mdir obj_dir \
    && ./obj_dir/VcontrollerTb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

/* dv/controllerVectors.svh */
// columns: name, instruction template, random fill mask,
// flags {aluSrc regDst regWrite aluSft zeroSrc}, aluOp code, illegal
task automatic loadVectors();
    // shifts by shamt, srl and rotr keep bit 21 out of the fill
    addVector("sll",   32'h0000_0100, R_DC,   5'b01110, 6'h14, 1'b0);
    addVector("srl",   32'h0000_0102, SRL_DC, 5'b01110, 6'h15, 1'b0);
    addVector("rotr",  32'h0020_0102, SRL_DC, 5'b01110, 6'h18, 1'b0);
    addVector("sra",   32'h0000_0103, R_DC,   5'b01110, 6'h19, 1'b0);
    // shifts by rs, bit 6 picks rotrv
    addVector("sllv",  32'h0000_0004, R_DC,   5'b01100, 6'h14, 1'b0);
    addVector("srlv",  32'h0000_0006, R_DC,   5'b01100, 6'h15, 1'b0);
    addVector("rotrv", 32'h0000_0046, R_DC,   5'b01100, 6'h18, 1'b0);
    addVector("srav",  32'h0000_0007, R_DC,   5'b01100, 6'h19, 1'b0);
    // register alu ops
    addVector("add",   32'h0000_0020, R_DC,   5'b01100, 6'h00, 1'b0);
    addVector("addu",  32'h0000_0021, R_DC,   5'b01100, 6'h20, 1'b0);
    addVector("sub",   32'h0000_0022, R_DC,   5'b01100, 6'h01, 1'b0);
    addVector("and",   32'h0000_0024, R_DC,   5'b01100, 6'h0f, 1'b0);
    addVector("or",    32'h0000_0025, R_DC,   5'b01100, 6'h10, 1'b0);
    addVector("xor",   32'h0000_0026, R_DC,   5'b01100, 6'h12, 1'b0);
    addVector("nor",   32'h0000_0027, R_DC,   5'b01100, 6'h11, 1'b0);
    addVector("slt",   32'h0000_002a, R_DC,   5'b01100, 6'h1b, 1'b0);
    addVector("sltu",  32'h0000_002b, R_DC,   5'b01100, 6'h22, 1'b0);
    addVector("movz",  32'h0000_000a, R_DC,   5'b01100, 6'h17, 1'b0);
    addVector("movn",  32'h0000_000b, R_DC,   5'b01100, 6'h16, 1'b0);
    addVector("mfhi",  32'h0000_0010, R_DC,   5'b01100, 6'h1e, 1'b0);
    addVector("mflo",  32'h0000_0012, R_DC,   5'b01100, 6'h1f, 1'b0);
    // hi/lo only, no register write
    addVector("mult",  32'h0000_0018, R_DC,   5'b00000, 6'h03, 1'b0);
    addVector("multu", 32'h0000_0019, R_DC,   5'b00000, 6'h21, 1'b0);
    addVector("mthi",  32'h0000_0011, R_DC,   5'b00000, 6'h1c, 1'b0);
    addVector("mtlo",  32'h0000_0013, R_DC,   5'b00000, 6'h1d, 1'b0);
    addVector("nop",   32'h0000_0000, NO_DC,  5'b00000, 6'h00, 1'b0);
    // special2 and special3
    addVector("mul",   32'h7000_0002, R_DC,   5'b01100, 6'h02, 1'b0);
    addVector("madd",  32'h7000_0000, R_DC,   5'b00000, 6'h04, 1'b0);
    addVector("msub",  32'h7000_0004, R_DC,   5'b00000, 6'h05, 1'b0);
    addVector("seh",   32'h7c00_0620, R_DC,   5'b01100, 6'h13, 1'b0);
    addVector("seb",   32'h7c00_0420, R_DC,   5'b01100, 6'h1a, 1'b0);
    // immediates, signed vs zero-extended
    addVector("addi",  32'h2000_0000, I_DC,   5'b10100, 6'h00, 1'b0);
    addVector("addiu", 32'h2400_0000, I_DC,   5'b10101, 6'h20, 1'b0);
    addVector("slti",  32'h2800_0000, I_DC,   5'b10100, 6'h1b, 1'b0);
    addVector("sltiu", 32'h2c00_0000, I_DC,   5'b10101, 6'h22, 1'b0);
    addVector("andi",  32'h3000_0000, I_DC,   5'b10101, 6'h0f, 1'b0);
    addVector("ori",   32'h3400_0000, I_DC,   5'b10101, 6'h10, 1'b0);
    addVector("xori",  32'h3800_0000, I_DC,   5'b10101, 6'h12, 1'b0);
    // unknown encodings
    addVector("badOp",  32'hc000_0000, I_DC,  5'b00000, 6'h00, 1'b1);
    addVector("jump",   32'h0800_0000, I_DC,  5'b00000, 6'h00, 1'b1);
    addVector("badFn",  32'h0000_000c, R_DC,  5'b00000, 6'h00, 1'b1);
    addVector("badFn2", 32'h7000_003f, R_DC,  5'b00000, 6'h00, 1'b1);
endtask

/* dv/controllerTb.sv */
module controllerTb;
    timeunit 1ns;
    timeprecision 1ps;

    import controlPkg::*;

    localparam logic [31:0] SEED        = 32'hba16_f2e6;
    localparam int          RESET_LIMIT = 50;

    // random fill masks
    localparam logic [31:0] R_DC   = 32'h03ff_f800;  // rs, rt, rd
    localparam logic [31:0] SRL_DC = 32'h03df_f800;  // bit 21 held
    localparam logic [31:0] I_DC   = 32'h03ff_ffff;  // rs, rt, imm
    localparam logic [31:0] NO_DC  = 32'h0000_0000;

    logic       clk;
    logic       rst;
    instrWord_t instr;
    ctrl_t      ctrl;
    logic       illegal;

    string       names[$];
    logic [31:0] words[$];
    logic [31:0] dcMasks[$];
    logic [10:0] expCtrls[$];
    logic        expIllegals[$];

    int          testsRun;
    int          testsFailed;
    int unsigned seedDiscard;
    bit          resetOk;

    controller UUT (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

    always #5 clk = ~clk;

    // release after 10 rising edges
    initial begin
        repeat (5) @(posedge clk);
        // writing add for the second half, must stay hidden too
        instr <= 32'h0000_0020;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

    task automatic addVector(input string name, input logic [31:0] word,
                             input logic [31:0] dc, input logic [4:0] flags,
                             input logic [5:0] op, input logic ill);
        names.push_back(name);
        words.push_back(word);
        dcMasks.push_back(dc);
        expCtrls.push_back({flags, op});
        expIllegals.push_back(ill);
    endtask

    `include "controllerVectors.svh"

    //////////////////////////////////////////////////////////////////////
    // reset phase, checked every cycle until release
    //////////////////////////////////////////////////////////////////////

    task automatic waitResetRelease(output bit ok);
        int cycles;
        bit bad;
        cycles = 0;
        bad    = 1'b0;
        while (rst && cycles < RESET_LIMIT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            // last pass lands one cycle after release
            if (ctrl !== 11'h000) begin
                $display("Fail reset: ctrl 0x%h expected 0x000", ctrl);
                bad = 1'b1;
            end
            if (illegal !== 1'b0) begin
                $display("Fail reset: illegal 0x%h expected 0x0", illegal);
                bad = 1'b1;
            end
        end
        ok = !rst;
        if (!ok) begin
            $display("reset was never released after %0d cycles", cycles);
            bad = 1'b1;
        end
        testsRun++;
        if (bad) testsFailed++;
        $display("[%s] reset", bad ? "bad" : "ok");
    endtask

    task automatic checkVector(input int idx, input logic [31:0] word);
        bit bad;
        bad = 1'b0;
        if (ctrl !== expCtrls[idx]) begin
            $display("Fail %s: ctrl 0x%h expected 0x%h (instr 0x%h)",
                     names[idx], ctrl, expCtrls[idx], word);
            bad = 1'b1;
        end
        if (illegal !== expIllegals[idx]) begin
            $display("Fail %s: illegal 0x%h expected 0x%h (instr 0x%h)",
                     names[idx], illegal, expIllegals[idx], word);
            bad = 1'b1;
        end
        testsRun++;
        if (bad) testsFailed++;
        $display("[%s] %s", bad ? "bad" : "ok", names[idx]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // back-to-back stream, result checked one edge later
    //////////////////////////////////////////////////////////////////////

    task automatic runVectors();
        logic [31:0] nextWord;
        logic [31:0] prevWord;
        nextWord = '0;
        prevWord = '0;
        for (int i = 0; i <= words.size(); i++) begin
            @(posedge clk);
            if (i < words.size()) begin
                nextWord = words[i] | ($urandom & dcMasks[i]);
                instr <= nextWord;
            end
            @(negedge clk);
            if (i > 0) checkVector(i - 1, prevWord);
            prevWord = nextWord;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        // illegal word early in reset, must stay hidden
        instr       = 32'hc000_0000;
        testsRun    = 0;
        testsFailed = 0;
        seedDiscard = $urandom(SEED);
        loadVectors();
        waitResetRelease(resetOk);
        if (resetOk) runVectors();
        $display("tests run: %0d, passed: %0d, failed: %0d",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog/controller.sv */
module controller (
    input  logic                   clk,
    input  logic                   rst,
    input  controlPkg::instrWord_t instr,
    output controlPkg::ctrl_t      ctrl,
    output logic                   illegal
);
    import controlPkg::*;

    ctrl_t specCtrl;
    ctrl_t mulCtrl;
    ctrl_t immCtrl;
    ctrl_t nextCtrl;
    logic  specValid;
    logic  mulValid;
    logic  immValid;
    logic  nextIllegal;

    //////////////////////////////////////////////////////////////////////
    // class decoders
    //////////////////////////////////////////////////////////////////////

    specialDecoder uSpecial (
        .instr (instr),
        .ctrl  (specCtrl),
        .valid (specValid)
    );

    mulExtDecoder uMulExt (
        .instr (instr),
        .ctrl  (mulCtrl),
        .valid (mulValid)
    );

    immDecoder uImm (
        .instr (instr),
        .ctrl  (immCtrl),
        .valid (immValid)
    );

    // opcode classes are disjoint, so at most one hit
    always_comb begin
        case ({specValid, mulValid, immValid})
            3'b100:  nextCtrl = specCtrl;
            3'b010:  nextCtrl = mulCtrl;
            3'b001:  nextCtrl = immCtrl;
            default: nextCtrl = '0;
        endcase
    end

    // no class claimed the word
    assign nextIllegal = !(specValid || mulValid || immValid);

    //////////////////////////////////////////////////////////////////////
    // output stage, one cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl    <= '0;
            illegal <= 1'b0;
        end else begin
            ctrl    <= nextCtrl;
            illegal <= nextIllegal;
        end
    end

    // decoders must never overlap
    assert property (@(posedge clk) $onehot0({specValid, mulValid, immValid}))
        else $error("controller: more than one class decoder valid");

endmodule

/* verilog/immDecoder.sv */
module immDecoder (
    input  controlPkg::instrWord_t instr,
    output controlPkg::ctrl_t      ctrl,
    output logic                   valid
);
    import controlPkg::*;

    logic   hit;
    logic   zeroExt;
    aluOp_t op;

    // opcode alone selects; rs, rt, imm go to the datapath
    always_comb begin
        hit     = 1'b1;
        zeroExt = 1'b1;
        op      = ALU_ADD;
        case (instr.i.opcode)
            OP_ADDI: begin
                op      = ALU_ADD;
                zeroExt = 1'b0;
            end
            OP_ADDIU: op = ALU_ADDU;
            OP_SLTI: begin
                op      = ALU_SLT;
                zeroExt = 1'b0;
            end
            OP_SLTIU: op = ALU_SLTU;
            // logic ops take the immediate unsigned
            OP_ANDI: op = ALU_AND;
            OP_ORI:  op = ALU_OR;
            OP_XORI: op = ALU_XOR;
            default: begin
                hit     = 1'b0;
                zeroExt = 1'b0;
            end
        endcase
    end

    assign valid = hit;

    // result always goes to rt
    always_comb begin
        ctrl = '0;
        if (valid) begin
            ctrl.aluSrc   = 1'b1;
            ctrl.regDst   = 1'b0;
            ctrl.regWrite = 1'b1;
            ctrl.aluSft   = 1'b0;
            ctrl.zeroSrc  = zeroExt;
            ctrl.aluOp    = op;
        end
    end

endmodule

/* verilog/mulExtDecoder.sv */
module mulExtDecoder (
    input  controlPkg::instrWord_t instr,
    output controlPkg::ctrl_t      ctrl,
    output logic                   valid
);
    import controlPkg::*;

    logic [INSTR_WIDTH-1:0] rawWord;
    logic                   isSpecial2;
    logic                   isSpecial3;
    logic                   hit;
    logic                   writes;
    aluOp_t                 op;

    assign rawWord    = instr;
    assign isSpecial2 = (instr.r.opcode == OP_SPECIAL2);
    assign isSpecial3 = (instr.r.opcode == OP_SPECIAL3);

    always_comb begin
        hit    = 1'b0;
        writes = 1'b0;
        op     = ALU_ADD;
        if (isSpecial2) begin
            // mul writes rd, madd/msub accumulate into hi/lo
            case (instr.r.funct)
                FN_MUL: begin
                    hit    = 1'b1;
                    writes = 1'b1;
                    op     = ALU_MUL;
                end
                FN_MADD: begin
                    hit = 1'b1;
                    op  = ALU_MADD;
                end
                FN_MSUB: begin
                    hit = 1'b1;
                    op  = ALU_MSUB;
                end
                default: hit = 1'b0;
            endcase
        end else if (isSpecial3) begin
            // bit 9 picks halfword over byte
            hit    = 1'b1;
            writes = 1'b1;
            op     = rawWord[9] ? ALU_SEH : ALU_SEB;
        end
    end

    assign valid = hit;

    always_comb begin
        ctrl = '0;
        if (valid) begin
            ctrl.regDst   = writes;
            ctrl.regWrite = writes;
            ctrl.aluOp    = op;
        end
    end

endmodule

/* verilog/specialDecoder.sv */
module specialDecoder (
    input  controlPkg::instrWord_t instr,
    output controlPkg::ctrl_t      ctrl,
    output logic                   valid
);
    import controlPkg::*;

    logic [INSTR_WIDTH-1:0] rawWord;
    logic                   isSpecial;
    logic                   isNop;
    logic                   hit;
    logic                   writes;
    logic                   shiftImm;
    aluOp_t                 op;

    // flat view for the single-bit selects
    assign rawWord   = instr;
    assign isSpecial = (instr.r.opcode == OP_SPECIAL);
    assign isNop     = (rawWord == '0);

    //////////////////////////////////////////////////////////////////////
    // funct table
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        hit      = 1'b1;
        writes   = 1'b1;
        shiftImm = 1'b0;
        op       = ALU_ADD;
        case (instr.r.funct)
            // shifts by shamt
            FN_SLL: begin
                op       = ALU_SLL;
                shiftImm = 1'b1;
            end
            FN_SRL: begin
                // bit 21 turns srl into rotr
                op       = rawWord[21] ? ALU_ROTR : ALU_SRL;
                shiftImm = 1'b1;
            end
            FN_SRA: begin
                op       = ALU_SRA;
                shiftImm = 1'b1;
            end
            // shifts by rs
            FN_SLLV: op = ALU_SLL;
            FN_SRLV: op = rawWord[6] ? ALU_ROTR : ALU_SRL;
            FN_SRAV: op = ALU_SRA;
            // arithmetic and logic
            FN_ADD:  op = ALU_ADD;
            FN_ADDU: op = ALU_ADDU;
            FN_SUB:  op = ALU_SUB;
            FN_AND:  op = ALU_AND;
            FN_OR:   op = ALU_OR;
            FN_XOR:  op = ALU_XOR;
            FN_NOR:  op = ALU_NOR;
            FN_SLT:  op = ALU_SLT;
            FN_SLTU: op = ALU_SLTU;
            // conditional moves
            FN_MOVN: op = ALU_MOVN;
            FN_MOVZ: op = ALU_MOVZ;
            // hi/lo reads land in rd
            FN_MFHI: op = ALU_MFHI;
            FN_MFLO: op = ALU_MFLO;
            // these only touch hi/lo
            FN_MULT: begin
                op     = ALU_MULT;
                writes = 1'b0;
            end
            FN_MULTU: begin
                op     = ALU_MULTU;
                writes = 1'b0;
            end
            FN_MTHI: begin
                op     = ALU_MTHI;
                writes = 1'b0;
            end
            FN_MTLO: begin
                op     = ALU_MTLO;
                writes = 1'b0;
            end
            default: begin
                hit    = 1'b0;
                writes = 1'b0;
            end
        endcase
        // all-zero word decodes as sll; force the nop result
        if (isNop) begin
            writes   = 1'b0;
            shiftImm = 1'b0;
            op       = ALU_ADD;
        end
    end

    assign valid = isSpecial && hit;

    // register operands only, so aluSrc and zeroSrc stay low
    always_comb begin
        ctrl = '0;
        if (valid) begin
            ctrl.regDst   = writes;
            ctrl.regWrite = writes;
            ctrl.aluSft   = shiftImm;
            ctrl.aluOp    = op;
        end
    end

endmodule

/* verilog/controlPkg.sv */
package controlPkg;

    //////////////////////////////////////////////////////////////////////
    // instruction word layout
    //////////////////////////////////////////////////////////////////////

    parameter int INSTR_WIDTH = 32;

    // opcode, rs and rt sit above the immediate
    localparam int IMM_WIDTH = INSTR_WIDTH - 16;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] regIdx_t;

    // register form
    typedef struct packed {
        opcode_t    opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rFields_t;

    // immediate form
    typedef struct packed {
        opcode_t                opcode;
        regIdx_t                rs;
        regIdx_t                rt;
        logic [IMM_WIDTH-1:0]   imm;
    } iFields_t;

    // same 32 bits, two field views
    typedef union packed {
        rFields_t r;
        iFields_t i;
    } instrWord_t;

    //////////////////////////////////////////////////////////////////////
    // major opcodes
    //////////////////////////////////////////////////////////////////////

    localparam opcode_t OP_SPECIAL  = 6'b000000;
    localparam opcode_t OP_SPECIAL2 = 6'b011100;
    localparam opcode_t OP_SPECIAL3 = 6'b011111;
    localparam opcode_t OP_ADDI     = 6'b001000;
    localparam opcode_t OP_ADDIU    = 6'b001001;
    localparam opcode_t OP_SLTI     = 6'b001010;
    localparam opcode_t OP_SLTIU    = 6'b001011;
    localparam opcode_t OP_ANDI     = 6'b001100;
    localparam opcode_t OP_ORI      = 6'b001101;
    localparam opcode_t OP_XORI     = 6'b001110;

    // special class, by funct
    localparam funct_t FN_SLL   = 6'b000000;
    localparam funct_t FN_SRL   = 6'b000010;
    localparam funct_t FN_SRA   = 6'b000011;
    localparam funct_t FN_SLLV  = 6'b000100;
    localparam funct_t FN_SRLV  = 6'b000110;
    localparam funct_t FN_SRAV  = 6'b000111;
    localparam funct_t FN_MOVZ  = 6'b001010;
    localparam funct_t FN_MOVN  = 6'b001011;
    localparam funct_t FN_MFHI  = 6'b010000;
    localparam funct_t FN_MTHI  = 6'b010001;
    localparam funct_t FN_MFLO  = 6'b010010;
    localparam funct_t FN_MTLO  = 6'b010011;
    localparam funct_t FN_MULT  = 6'b011000;
    localparam funct_t FN_MULTU = 6'b011001;
    localparam funct_t FN_ADD   = 6'b100000;
    localparam funct_t FN_ADDU  = 6'b100001;
    localparam funct_t FN_SUB   = 6'b100010;
    localparam funct_t FN_AND   = 6'b100100;
    localparam funct_t FN_OR    = 6'b100101;
    localparam funct_t FN_XOR   = 6'b100110;
    localparam funct_t FN_NOR   = 6'b100111;
    localparam funct_t FN_SLT   = 6'b101010;
    localparam funct_t FN_SLTU  = 6'b101011;

    // special2 class
    localparam funct_t FN_MADD  = 6'b000000;
    localparam funct_t FN_MUL   = 6'b000010;
    localparam funct_t FN_MSUB  = 6'b000100;

    //////////////////////////////////////////////////////////////////////
    // alu operations and control word
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        ALU_ADD   = 6'b000000,
        ALU_SUB   = 6'b000001,
        ALU_MUL   = 6'b000010,
        ALU_MULT  = 6'b000011,
        ALU_MADD  = 6'b000100,
        ALU_MSUB  = 6'b000101,
        ALU_AND   = 6'b001111,
        ALU_OR    = 6'b010000,
        ALU_NOR   = 6'b010001,
        ALU_XOR   = 6'b010010,
        ALU_SEH   = 6'b010011,
        ALU_SLL   = 6'b010100,
        ALU_SRL   = 6'b010101,
        ALU_MOVN  = 6'b010110,
        ALU_MOVZ  = 6'b010111,
        ALU_ROTR  = 6'b011000,
        ALU_SRA   = 6'b011001,
        ALU_SEB   = 6'b011010,
        ALU_SLT   = 6'b011011,
        ALU_MTHI  = 6'b011100,
        ALU_MTLO  = 6'b011101,
        ALU_MFHI  = 6'b011110,
        ALU_MFLO  = 6'b011111,
        ALU_ADDU  = 6'b100000,
        ALU_MULTU = 6'b100001,
        ALU_SLTU  = 6'b100010
    } aluOp_t;

    // 11 bits, msb first
    typedef struct packed {
        logic   aluSrc;     // immediate as operand b
        logic   regDst;     // write rd, not rt
        logic   regWrite;
        logic   aluSft;     // shift amount from shamt
        logic   zeroSrc;    // zero-extend the immediate
        aluOp_t aluOp;
    } ctrl_t;

endpackage
